//--- source/cube_pkg.sv
// shared types, 480p display timing, framebuffer geometry
// palette and drawing constants for the cube design
package cube_pkg;

    typedef logic signed [15:0] coord_t;    // screen and framebuffer position
    typedef logic [1:0]         cidx_t;     // colour index
    typedef logic [3:0]         chan_t;     // one colour channel
    typedef logic [13:0]        fb_addr_t;  // framebuffer word address

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_INIT,
        SEQ_DRAW,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        LN_IDLE,
        LN_INIT,
        LN_DRAW
    } line_state_t;

    // horizontal timing in pixels
    localparam coord_t H_ACTIVE = 640;
    localparam coord_t H_FRONT  = 16;
    localparam coord_t H_SYNC   = 96;
    localparam coord_t H_BACK   = 48;
    localparam coord_t H_TOTAL  = 800;

    // vertical timing in lines
    localparam coord_t V_ACTIVE = 480;
    localparam coord_t V_FRONT  = 10;
    localparam coord_t V_SYNC   = 2;
    localparam coord_t V_BACK   = 33;
    localparam coord_t V_TOTAL  = 525;

    localparam coord_t FB_WIDTH       = 160;
    localparam coord_t FB_HEIGHT      = 90;
    localparam int     FB_SCALE_SHIFT = 2;    // each fb pixel is 4x4 on screen
    localparam coord_t LB_TOP         = 60;   // 16:9 letterbox rows
    localparam coord_t LB_BOTTOM      = 420;

    localparam int    EDGE_CNT  = 9;
    localparam cidx_t EDGE_CIDX = 2'd2;      // green

    // 12-bit rgb, entry 3 first
    localparam logic [3:0][11:0] PALETTE = {12'hF00, 12'h0F0, 12'hFFF, 12'h000};

endpackage

//--- source/display_timings_480p.sv
// 640x480 display timing generator
// pixel and line counters with syncs, data enable and pulses
module display_timings_480p
    import cube_pkg::*;
(
    input  logic   clk_pix,
    input  logic   arst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame,
    output logic   line
);

    localparam coord_t HS_START = H_ACTIVE + H_FRONT;      // 656
    localparam coord_t HS_END   = HS_START + H_SYNC - 1;   // 751
    localparam coord_t VS_START = V_ACTIVE + V_FRONT;      // 490
    localparam coord_t VS_END   = VS_START + V_SYNC - 1;   // 491
    localparam coord_t H_LAST   = H_TOTAL - 1;
    localparam coord_t V_LAST   = V_TOTAL - 1;

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == H_LAST);
    assign frame_end = line_end && (sy == V_LAST);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (line_end) begin
                sx <= '0;
                sy <= (sy == V_LAST) ? '0 : sy + 16'sd1;
            end else begin
                sx <= sx + 16'sd1;
            end
        end
    end

    // everything below comes straight off the counters
    always_comb begin
        hsync = !((sx >= HS_START) && (sx <= HS_END));  // active low
        vsync = !((sy >= VS_START) && (sy <= VS_END));
        de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        frame = frame_end;
        line  = line_end;
    end

    // counter never runs past the end of the line
    a_sx_range: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        sx <= H_LAST
    );

endmodule

//--- source/draw_line.sv
// Bresenham line engine
// one framebuffer coordinate per cycle between two endpoints
module draw_line
    import cube_pkg::*;
(
    input  logic   clk_pix,
    input  logic   arst_n,
    input  logic   start,
    input  coord_t x0,
    input  coord_t y0,
    input  coord_t x1,
    input  coord_t y1,
    output coord_t x,
    output coord_t y,
    output logic   busy,
    output logic   done
);

    line_state_t state;

    coord_t dx;        // absolute x distance
    coord_t dy;        // negated absolute y distance
    coord_t err;
    coord_t e2;        // twice the error
    coord_t dx_abs;
    coord_t dy_neg;
    coord_t err_next;
    logic   x_inc;     // 1 = step right
    logic   y_inc;     // 1 = step down
    logic   step_x;
    logic   step_y;
    logic   last_pix;

    always_comb begin
        dx_abs   = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy_neg   = (y1 > y0) ? y0 - y1 : y1 - y0;
        e2       = err <<< 1;
        step_x   = (e2 >= dy);  // both tests use the old error
        step_y   = (e2 <= dx);
        err_next = err + (step_x ? dy : '0) + (step_y ? dx : '0);
        last_pix = (x == x1) && (y == y1);
    end

    assign busy = (state == LN_DRAW);

    // control
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= LN_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LN_IDLE: if (start) state <= LN_INIT;
                LN_INIT: state <= LN_DRAW;
                LN_DRAW: begin
                    if (last_pix) begin
                        state <= LN_IDLE;
                        done  <= 1'b1;  // cycle after the last pixel
                    end
                end
                default: state <= LN_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_pix) begin
        case (state)
            LN_INIT: begin
                dx    <= dx_abs;
                dy    <= dy_neg;
                err   <= dx_abs + dy_neg;
                x_inc <= (x0 < x1);
                y_inc <= (y0 < y1);
                x     <= x0;  // first endpoint is plotted as is
                y     <= y0;
            end
            LN_DRAW: begin
                if (!last_pix) begin
                    err <= err_next;
                    if (step_x) x <= x_inc ? x + 16'sd1 : x - 16'sd1;
                    if (step_y) y <= y_inc ? y + 16'sd1 : y - 16'sd1;
                end
            end
            default: ;
        endcase
    end

    // sequencer has to wait for done before the next line
    a_no_start_busy: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        start |-> !busy
    );

endmodule

//--- source/cube_sequencer.sv
// cube edge table and the FSM that walks it
// hands one edge at a time to the line engine
module cube_sequencer
    import cube_pkg::*;
(
    input  logic   clk_pix,
    input  logic   arst_n,
    input  logic   frame,
    input  logic   done,
    output logic   start,
    output coord_t x0,
    output coord_t y0,
    output coord_t x1,
    output coord_t y1,
    output logic   cube_done
);

    // x0, y0, x1, y1 in framebuffer coordinates
    localparam coord_t EDGE_TABLE [EDGE_CNT][4] = '{
        '{ 65, 30, 115, 30},  // front face
        '{115, 30, 115, 80},
        '{115, 80,  65, 80},
        '{ 65, 80,  65, 30},
        '{ 65, 80,  45, 60},  // back and joining edges
        '{ 45, 60,  45, 10},
        '{ 45, 10,  65, 30},
        '{ 45, 10,  95, 10},
        '{ 95, 10, 115, 30}
    };

    seq_state_t state;
    logic [3:0] edge_idx;
    logic       last_edge;

    assign last_edge = (edge_idx == 4'(EDGE_CNT - 1));
    assign cube_done = (state == SEQ_DONE);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state    <= SEQ_IDLE;
            edge_idx <= '0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                SEQ_IDLE: if (frame) state <= SEQ_INIT;
                SEQ_INIT: begin
                    start <= 1'b1;  // coords land in the same cycle
                    state <= SEQ_DRAW;
                end
                SEQ_DRAW: begin
                    if (done) begin
                        if (last_edge) begin
                            state <= SEQ_DONE;
                        end else begin
                            edge_idx <= edge_idx + 4'd1;
                            state    <= SEQ_INIT;
                        end
                    end
                end
                SEQ_DONE: state <= SEQ_DONE;  // hold until reset
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // endpoints stay put through the whole line
    always_ff @(posedge clk_pix) begin
        if (state == SEQ_INIT) begin
            x0 <= EDGE_TABLE[edge_idx][0];
            y0 <= EDGE_TABLE[edge_idx][1];
            x1 <= EDGE_TABLE[edge_idx][2];
            y1 <= EDGE_TABLE[edge_idx][3];
        end
    end

    a_edge_idx: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        edge_idx < 4'(EDGE_CNT)
    );

endmodule

//--- source/framebuffer.sv
// colour index framebuffer, written by the line engine
// read back at 4x scale inside the letterbox, then palette lookup
module framebuffer
    import cube_pkg::*;
(
    input  logic   clk_pix,
    input  logic   we,
    input  coord_t x,
    input  coord_t y,
    input  coord_t sx,
    input  coord_t sy,
    output chan_t  red,
    output chan_t  green,
    output chan_t  blue
);

    cidx_t mem [FB_WIDTH * FB_HEIGHT];

    fb_addr_t wr_addr;
    fb_addr_t rd_addr;
    coord_t   rd_row;
    coord_t   rd_col;
    logic     rd_en;
    logic     rd_valid;   // rd_en one cycle later
    cidx_t    rd_cidx;

    // screen starts black
    initial begin
        for (int i = 0; i < FB_WIDTH * FB_HEIGHT; i++) begin
            mem[i] = '0;
        end
    end

    assign wr_addr = fb_addr_t'(y) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(x);

    // letterbox window and scaled read position
    always_comb begin
        rd_en   = (sy >= LB_TOP) && (sy < LB_BOTTOM) && (sx < H_ACTIVE);
        rd_row  = (sy - LB_TOP) >>> FB_SCALE_SHIFT;
        rd_col  = sx >>> FB_SCALE_SHIFT;
        rd_addr = fb_addr_t'(rd_row) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(rd_col);
    end

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[wr_addr] <= EDGE_CIDX;
        end
    end

    // registered read port
    always_ff @(posedge clk_pix) begin
        if (rd_en) begin
            rd_cidx <= mem[rd_addr];
        end
        rd_valid <= rd_en;
    end

    always_comb begin
        if (rd_valid) begin
            {red, green, blue} = PALETTE[rd_cidx];
        end else begin
            {red, green, blue} = '0;  // borders and blanking
        end
    end

    // line engine coordinates have to land inside the buffer
    a_wr_inside: assert property (
        @(posedge clk_pix)
        we |-> (x >= 0) && (x < FB_WIDTH) && (y >= 0) && (y < FB_HEIGHT)
    );

endmodule

//--- source/top_cube.sv
// top level of the wireframe cube display
// timing, drawing and framebuffer, with syncs delayed to match colour
module top_cube
    import cube_pkg::*;
(
    input  logic  clk_pix,
    input  logic  arst_n,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output chan_t red,
    output chan_t green,
    output chan_t blue,
    output logic  cube_done
);

    coord_t sx;
    coord_t sy;
    logic   tim_hsync;
    logic   tim_vsync;
    logic   tim_de;
    logic   frame;

    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    coord_t fb_x;
    coord_t fb_y;
    logic   draw_start;
    logic   drawing;
    logic   draw_done;

    display_timings_480p u_timings (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (tim_hsync),
        .vsync   (tim_vsync),
        .de      (tim_de),
        .frame   (frame),
        .line    ()
    );

    cube_sequencer u_seq (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .frame     (frame),
        .done      (draw_done),
        .start     (draw_start),
        .x0        (x0),
        .y0        (y0),
        .x1        (x1),
        .y1        (y1),
        .cube_done (cube_done)
    );

    draw_line u_line (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .start   (draw_start),
        .x0      (x0),
        .y0      (y0),
        .x1      (x1),
        .y1      (y1),
        .x       (fb_x),
        .y       (fb_y),
        .busy    (drawing),
        .done    (draw_done)
    );

    framebuffer u_fb (
        .clk_pix (clk_pix),
        .we      (drawing),  // one pixel per busy cycle
        .x       (fb_x),
        .y       (fb_y),
        .sx      (sx),
        .sy      (sy),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    // fb read takes a cycle, delay the controls to line up
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= tim_hsync;
            vsync <= tim_vsync;
            de    <= tim_de;
        end
    end

endmodule

//--- sim/tb_clock.sv
// testbench clock and reset generator
// free running pixel clock, reset held low for a fixed number of cycles
module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_pix,
    output logic arst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #(PERIOD / 2) clk_pix = ~clk_pix;
    end

    // release on a falling edge like every other input
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_pix);
        arst_n = 1'b1;
    end

endmodule

//--- sim/tb_top_cube.sv
// testbench for the wireframe cube display
// reference framebuffer model, per pixel comparison of syncs and colour, watchdog
module tb_top_cube
    import cube_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int H_TOT      = int'(H_TOTAL);
    localparam int V_TOT      = int'(V_TOTAL);
    localparam int H_ACT      = int'(H_ACTIVE);
    localparam int V_ACT      = int'(V_ACTIVE);
    localparam int HS_FIRST   = H_ACT + int'(H_FRONT);
    localparam int HS_LAST    = HS_FIRST + int'(H_SYNC) - 1;
    localparam int VS_FIRST   = V_ACT + int'(V_FRONT);
    localparam int VS_LAST    = VS_FIRST + int'(V_SYNC) - 1;
    localparam int FB_W       = int'(FB_WIDTH);
    localparam int FB_SIZE    = int'(FB_WIDTH) * int'(FB_HEIGHT);
    localparam int LB_T       = int'(LB_TOP);
    localparam int LB_B       = int'(LB_BOTTOM);
    localparam int RUN_FRAMES = 2;
    // twice the frames actually checked
    localparam longint TIMEOUT = 64'd4 * longint'(H_TOT) * longint'(V_TOT) * CLK_PERIOD;

    // cube edges in fb coordinates, x0 y0 x1 y1
    localparam int EDGES [EDGE_CNT][4] = '{
        '{ 65, 30, 115, 30},
        '{115, 30, 115, 80},
        '{115, 80,  65, 80},
        '{ 65, 80,  65, 30},
        '{ 65, 80,  45, 60},
        '{ 45, 60,  45, 10},
        '{ 45, 10,  65, 30},
        '{ 45, 10,  95, 10},
        '{ 95, 10, 115, 30}
    };

    logic  clk_pix;
    logic  arst_n;
    logic  hsync;
    logic  vsync;
    logic  de;
    logic  cube_done;
    chan_t red;
    chan_t green;
    chan_t blue;

    cidx_t model_fb [FB_SIZE];

    int   pos_x       = 0;   // counter position behind the current outputs
    int   pos_y       = 0;
    int   frame_no    = 0;
    int   hs_low_cnt  = 0;
    int   de_cnt      = 0;
    int   vs_lines    = 0;
    int   de_lines    = 0;
    int   cyc         = 0;
    int   last_fall   = -1;
    int   error_count = 0;
    logic prev_hsync  = 1'b1;
    logic done_seen   = 1'b0;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock (
        .clk_pix (clk_pix),
        .arst_n  (arst_n)
    );

    top_cube dut (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .cube_done (cube_done)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s, expected %0d, got %0d",
                     $time, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic void plot(input int px, input int py);
        model_fb[py * FB_W + px] = EDGE_CIDX;
    endfunction

    // bresenham over every edge of the table
    function automatic void build_model();
        int x;
        int y;
        int xe;
        int ye;
        int dx;
        int dy;
        int err;
        int e2;
        int stx;
        int sty;
        for (int i = 0; i < FB_SIZE; i++) begin
            model_fb[i] = '0;
        end
        for (int e = 0; e < EDGE_CNT; e++) begin
            x   = EDGES[e][0];
            y   = EDGES[e][1];
            xe  = EDGES[e][2];
            ye  = EDGES[e][3];
            dx  = (xe > x) ? xe - x : x - xe;
            dy  = (ye > y) ? y - ye : ye - y;  // negated
            err = dx + dy;
            stx = (x < xe) ? 1 : -1;
            sty = (y < ye) ? 1 : -1;
            plot(x, y);
            while ((x != xe) || (y != ye)) begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x   += stx;
                end
                if (e2 <= dx) begin  // old error, not the updated one
                    err += dx;
                    y   += sty;
                end
                plot(x, y);
            end
        end
    endfunction

    function automatic logic [11:0] palette_rgb(input cidx_t c);
        case (c)
            2'd1:    return 12'hFFF;
            2'd2:    return 12'h0F0;
            2'd3:    return 12'hF00;
            default: return 12'h000;
        endcase
    endfunction

    // colour for a counter position, blank fb until the cube is drawn
    function automatic logic [11:0] expected_rgb(input int px, input int py, input bit drawn);
        int row;
        int col;
        if ((py >= LB_T) && (py < LB_B) && (px < H_ACT)) begin
            row = (py - LB_T) >> FB_SCALE_SHIFT;
            col = px >> FB_SCALE_SHIFT;
            return drawn ? palette_rgb(model_fb[row * FB_W + col]) : 12'h000;
        end
        return 12'h000;
    endfunction

    task automatic check_reset_state();
        check_value(32'(hsync), 32'd1, "hsync in reset");
        check_value(32'(vsync), 32'd1, "vsync in reset");
        check_value(32'(de), 32'd0, "de in reset");
        check_value(32'(cube_done), 32'd0, "cube_done in reset");
        check_value(32'({red, green, blue}), 32'd0, "colour in reset");
    endtask

    task automatic check_position();
        string where;
        int    exp_hs;
        int    exp_vs;
        int    exp_de;
        where  = $sformatf("frame %0d x %0d y %0d", frame_no, pos_x, pos_y);
        exp_hs = ((pos_x >= HS_FIRST) && (pos_x <= HS_LAST)) ? 0 : 1;
        exp_vs = ((pos_y >= VS_FIRST) && (pos_y <= VS_LAST)) ? 0 : 1;
        exp_de = ((pos_x < H_ACT) && (pos_y < V_ACT)) ? 1 : 0;
        check_value(32'(hsync), 32'(exp_hs), {"hsync at ", where});
        check_value(32'(vsync), 32'(exp_vs), {"vsync at ", where});
        check_value(32'(de), 32'(exp_de), {"de at ", where});
        check_value(32'({red, green, blue}), 32'(expected_rgb(pos_x, pos_y, frame_no >= 1)),
                    {"colour at ", where});

        // drawing starts on the frame pulse and fits inside line 0
        if (frame_no == 0) begin
            check_value(32'(cube_done), 32'd0, {"cube_done early at ", where});
        end else if (pos_y >= 1) begin
            check_value(32'(cube_done), 32'd1, {"cube_done late at ", where});
        end
        if (done_seen) begin
            check_value(32'(cube_done), 32'd1, {"cube_done dropped at ", where});
        end
        if (cube_done) done_seen = 1'b1;

        if (!hsync) hs_low_cnt++;
        if (de) de_cnt++;
        if (prev_hsync && !hsync) begin
            if (last_fall >= 0) check_value(32'(cyc - last_fall), 32'(H_TOT), "line period");
            last_fall = cyc;
        end
        prev_hsync = hsync;
        cyc++;
        if (pos_x == 0) begin
            if (!vsync) vs_lines++;
            if (de) de_lines++;
        end
        if (pos_x == H_TOT - 1) begin
            check_value(32'(hs_low_cnt), 32'(HS_LAST - HS_FIRST + 1), {"hsync width ", where});
            check_value(32'(de_cnt), 32'((pos_y < V_ACT) ? H_ACT : 0), {"de per line ", where});
            hs_low_cnt = 0;
            de_cnt     = 0;
            if (pos_y == V_TOT - 1) begin
                check_value(32'(vs_lines), 32'(VS_LAST - VS_FIRST + 1), "vsync lines");
                check_value(32'(de_lines), 32'(V_ACT), "active lines");
                vs_lines = 0;
                de_lines = 0;
            end
        end
    endtask

    task automatic advance_position();
        pos_x++;
        if (pos_x == H_TOT) begin
            pos_x = 0;
            pos_y++;
            if (pos_y == V_TOT) begin
                pos_y = 0;
                frame_no++;
            end
        end
    endtask

    // sample at the falling edge, half a cycle after the outputs settle
    initial begin : compare
        logic in_reset;
        build_model();
        while (frame_no < RUN_FRAMES) begin
            @(posedge clk_pix);
            in_reset = !arst_n;
            @(negedge clk_pix);
            if (in_reset) begin
                check_reset_state();
            end else begin
                check_position();
                advance_position();
            end
        end
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("simulation timed out at %0t before all frames were checked", $time);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- project.f
source/cube_pkg.sv
source/display_timings_480p.sv
source/draw_line.sv
source/cube_sequencer.sv
source/framebuffer.sv
source/top_cube.sv
sim/tb_clock.sv
sim/tb_top_cube.sv

//--- Makefile
# Verilator build and run for the cube display testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_top_cube
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Regression passed" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
